// ==== src/stamofu_pkg.sv ====
// --------------------------------------------------------------------------
// store/amo/fence issue queue definitions
// queue sizes, tag layout, packed entry and issue formats, and the
// lowest-set-bit picker used for slot allocation and issue select
// --------------------------------------------------------------------------

`default_nettype none

package stamofu_pkg;

    localparam int IQ_ENTRIES     = 8;
    localparam int PR_COUNT_LOG   = 6;
    localparam int PRF_BANK_COUNT = 4;
    localparam int PRF_BANK_LOG   = 2;
    localparam int PR_UPPER_W     = PR_COUNT_LOG - PRF_BANK_LOG;
    localparam int ROB_INDEX_W    = 7;
    localparam int CQ_INDEX_W     = 4;
    localparam int OP_W           = 4;
    localparam int IMM_W          = 12;

    // physical register tag, bank in the low bits
    typedef struct packed {
        logic [PR_UPPER_W-1:0]   upper;
        logic [PRF_BANK_LOG-1:0] bank;
    } pr_t;

    typedef struct packed {
        pr_t  pr;
        logic ready;
        logic is_zero;
    } operand_t;

    typedef struct packed {
        logic                   is_store;
        logic                   is_amo;
        logic                   is_fence;
        logic [OP_W-1:0]        op;
        logic [IMM_W-1:0]       imm12;
        logic                   mem_aq;
        logic                   io_aq;
        logic [ROB_INDEX_W-1:0] rob_index;
        logic [CQ_INDEX_W-1:0]  cq_index;
    } op_info_t;

    typedef struct packed {
        op_info_t info;
        operand_t a;
        operand_t b;
    } iq_enq_t;

    typedef struct packed {
        logic    valid;
        iq_enq_t payload;
    } iq_entry_t;

    typedef struct packed {
        logic [PRF_BANK_COUNT-1:0]                 valid;
        logic [PRF_BANK_COUNT-1:0][PR_UPPER_W-1:0] upper;
    } wb_bus_t;

    typedef struct packed {
        op_info_t                info;
        logic                    a_forward;
        logic                    a_is_zero;
        logic [PRF_BANK_LOG-1:0] a_bank;
        logic                    b_forward;
        logic                    b_is_zero;
        logic [PRF_BANK_LOG-1:0] b_bank;
    } issue_t;

    typedef struct packed {
        logic a_valid;
        pr_t  a_pr;
        logic b_valid;
        pr_t  b_pr;
    } prf_req_t;

    // one-hot of the lowest request, plus everything at or above it
    typedef struct packed {
        logic [IQ_ENTRIES-1:0] one_hot;
        logic [IQ_ENTRIES-1:0] mask;
    } pick_t;

    function automatic pick_t pick_lsb(input logic [IQ_ENTRIES-1:0] req);
        pick_t res;
        logic  found;
        res   = '0;
        found = 1'b0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (req[i] && !found) begin
                res.one_hot[i] = 1'b1;
                found          = 1'b1;
            end
            res.mask[i] = found;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== src/iq_entry_array.sv ====
// --------------------------------------------------------------------------
// issue queue entry array
// holds the queued ops with the oldest at index 0, allocates the lowest
// free slot on enqueue, shifts younger entries down over an issued slot
// and latches operand forwards into the ready bits
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module iq_entry_array (
    input  wire                                           CLK,
    input  wire                                           nRST,

    input  wire                                           enq_valid,
    input  wire  stamofu_pkg::iq_enq_t                    enq,
    output logic                                          enq_ready,

    input  wire  [stamofu_pkg::IQ_ENTRIES-1:0]            issue_mask,
    input  wire  [stamofu_pkg::IQ_ENTRIES-1:0]            a_fwd,
    input  wire  [stamofu_pkg::IQ_ENTRIES-1:0]            b_fwd,

    output stamofu_pkg::iq_entry_t [stamofu_pkg::IQ_ENTRIES-1:0] entries
);

    import stamofu_pkg::*;

    // state
    logic    [IQ_ENTRIES-1:0] valid_q;
    iq_enq_t [IQ_ENTRIES-1:0] payload_q;

    // allocation
    logic [IQ_ENTRIES-1:0] free_vec;
    pick_t                 alloc_pick;
    logic [IQ_ENTRIES-1:0] alloc_oh;

    // one extra empty slot above the top so every slot has a source above
    logic    [IQ_ENTRIES:0] valid_ext;
    logic    [IQ_ENTRIES:0] alloc_ext;
    logic    [IQ_ENTRIES:0] a_fwd_ext;
    logic    [IQ_ENTRIES:0] b_fwd_ext;
    iq_enq_t [IQ_ENTRIES:0] payload_ext;

    // per-slot source after the compaction mux
    logic    [IQ_ENTRIES-1:0] src_valid;
    logic    [IQ_ENTRIES-1:0] src_alloc;
    logic    [IQ_ENTRIES-1:0] src_a_fwd;
    logic    [IQ_ENTRIES-1:0] src_b_fwd;
    iq_enq_t [IQ_ENTRIES-1:0] src_payload;

    logic    [IQ_ENTRIES-1:0] valid_d;
    iq_enq_t [IQ_ENTRIES-1:0] payload_d;

    // ----------------------------------------------------------------------
    // enqueue allocation

    // free space is judged on the entries present at the start of the cycle
    assign free_vec   = ~valid_q;
    assign alloc_pick = pick_lsb(free_vec);
    assign alloc_oh   = alloc_pick.one_hot & {IQ_ENTRIES{enq_valid}};
    assign enq_ready  = |free_vec;

    assign valid_ext   = {1'b0, valid_q};
    assign alloc_ext   = {1'b0, alloc_oh};
    assign a_fwd_ext   = {1'b0, a_fwd};
    assign b_fwd_ext   = {1'b0, b_fwd};
    assign payload_ext = {enq, payload_q};

    // ----------------------------------------------------------------------
    // compaction and next state

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (issue_mask[i]) begin
                src_valid[i]   = valid_ext[i+1];
                src_alloc[i]   = alloc_ext[i+1];
                src_a_fwd[i]   = a_fwd_ext[i+1];
                src_b_fwd[i]   = b_fwd_ext[i+1];
                src_payload[i] = payload_ext[i+1];
            end else begin
                src_valid[i]   = valid_ext[i];
                src_alloc[i]   = alloc_ext[i];
                src_a_fwd[i]   = a_fwd_ext[i];
                src_b_fwd[i]   = b_fwd_ext[i];
                src_payload[i] = payload_ext[i];
            end
        end

        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (src_valid[i]) begin
                valid_d[i]           = 1'b1;
                payload_d[i]         = src_payload[i];
                // a forward seen this cycle sticks as ready
                payload_d[i].a.ready = src_payload[i].a.ready | src_a_fwd[i];
                payload_d[i].b.ready = src_payload[i].b.ready | src_b_fwd[i];
            end else begin
                // empty source, enqueue lands here if it picked that slot
                valid_d[i]   = src_alloc[i];
                payload_d[i] = enq;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge CLK) begin
        payload_q <= payload_d;
    end

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            entries[i].valid   = valid_q[i];
            entries[i].payload = payload_q[i];
        end
    end

endmodule

`default_nettype wire

// ==== src/operand_wakeup.sv ====
// --------------------------------------------------------------------------
// operand wakeup
// checks every queued operand against the banked writeback bus and
// flags a same-cycle forward per entry
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module operand_wakeup (
    input  wire stamofu_pkg::iq_entry_t [stamofu_pkg::IQ_ENTRIES-1:0] entries,
    input  wire stamofu_pkg::wb_bus_t                                 wb,

    output logic [stamofu_pkg::IQ_ENTRIES-1:0]                        a_fwd,
    output logic [stamofu_pkg::IQ_ENTRIES-1:0]                        b_fwd
);

    import stamofu_pkg::*;

    // the operand's bank selects which writeback lane to look at
    function automatic logic fwd_hit(input pr_t pr, input wb_bus_t bus);
        logic hit;
        hit = bus.valid[pr.bank] && (bus.upper[pr.bank] == pr.upper);
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            a_fwd[i] = entries[i].valid && fwd_hit(entries[i].payload.a.pr, wb);
            b_fwd[i] = entries[i].valid && fwd_hit(entries[i].payload.b.pr, wb);
        end
    end

endmodule

`default_nettype wire

// ==== src/issue_select.sv ====
// --------------------------------------------------------------------------
// issue select
// finds entries whose operands are ready, forwarding or zero, picks the
// oldest one and muxes it out with its register file read requests
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module issue_select (
    input  wire stamofu_pkg::iq_entry_t [stamofu_pkg::IQ_ENTRIES-1:0] entries,
    input  wire [stamofu_pkg::IQ_ENTRIES-1:0]                         a_fwd,
    input  wire [stamofu_pkg::IQ_ENTRIES-1:0]                         b_fwd,
    input  wire                                                       pipeline_ready,

    output logic                                                      issue_valid,
    output stamofu_pkg::issue_t                                       issue,
    output stamofu_pkg::prf_req_t                                     prf_req,
    output logic [stamofu_pkg::IQ_ENTRIES-1:0]                        issue_mask
);

    import stamofu_pkg::*;

    logic [IQ_ENTRIES-1:0] valid_vec;
    logic [IQ_ENTRIES-1:0] a_ok;
    logic [IQ_ENTRIES-1:0] b_ok;
    logic [IQ_ENTRIES-1:0] issuable;
    pick_t                 issue_pick;

    // ----------------------------------------------------------------------
    // ready check and oldest-first pick

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            valid_vec[i] = entries[i].valid;
            a_ok[i] = entries[i].payload.a.ready | a_fwd[i] | entries[i].payload.a.is_zero;
            b_ok[i] = entries[i].payload.b.ready | b_fwd[i] | entries[i].payload.b.is_zero;
        end
    end

    assign issuable    = {IQ_ENTRIES{pipeline_ready}} & valid_vec & a_ok & b_ok;
    assign issue_pick  = pick_lsb(issuable);
    assign issue_valid = |issuable;

    // everything at or above the picked slot shifts down one
    assign issue_mask  = issue_pick.mask;

    // ----------------------------------------------------------------------
    // one-hot output mux

    always_comb begin
        issue   = '0;
        prf_req = '0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (issue_pick.one_hot[i]) begin
                issue.info      |= entries[i].payload.info;
                issue.a_forward |= a_fwd[i];
                issue.a_is_zero |= entries[i].payload.a.is_zero;
                issue.a_bank    |= entries[i].payload.a.pr.bank;
                issue.b_forward |= b_fwd[i];
                issue.b_is_zero |= entries[i].payload.b.is_zero;
                issue.b_bank    |= entries[i].payload.b.pr.bank;

                // forwarded or zero operands need no register read
                prf_req.a_valid |= ~a_fwd[i] & ~entries[i].payload.a.is_zero;
                prf_req.a_pr    |= entries[i].payload.a.pr;
                prf_req.b_valid |= ~b_fwd[i] & ~entries[i].payload.b.is_zero;
                prf_req.b_pr    |= entries[i].payload.b.pr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/stamofu_iq.sv ====
// --------------------------------------------------------------------------
// store/amo/fence issue queue
// compacting queue of memory ops, oldest at index 0; wakes operands from
// the writeback bus and issues the oldest ready op each cycle
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module stamofu_iq (
    input  wire                        CLK,
    input  wire                        nRST,

    // enqueue
    input  wire                        enq_valid,
    input  wire stamofu_pkg::iq_enq_t  enq,
    output logic                       enq_ready,

    // writeback bus
    input  wire stamofu_pkg::wb_bus_t  wb,

    // issue to pipeline
    input  wire                        pipeline_ready,
    output logic                       issue_valid,
    output stamofu_pkg::issue_t        issue,
    output stamofu_pkg::prf_req_t      prf_req
);

    import stamofu_pkg::*;

    iq_entry_t [IQ_ENTRIES-1:0] entries;
    logic      [IQ_ENTRIES-1:0] a_fwd;
    logic      [IQ_ENTRIES-1:0] b_fwd;
    logic      [IQ_ENTRIES-1:0] issue_mask;

    iq_entry_array u_array (
        .CLK        (CLK),
        .nRST       (nRST),
        .enq_valid  (enq_valid),
        .enq        (enq),
        .enq_ready  (enq_ready),
        .issue_mask (issue_mask),
        .a_fwd      (a_fwd),
        .b_fwd      (b_fwd),
        .entries    (entries)
    );

    operand_wakeup u_wakeup (
        .entries (entries),
        .wb      (wb),
        .a_fwd   (a_fwd),
        .b_fwd   (b_fwd)
    );

    // select sees this cycle's forwards directly
    issue_select u_select (
        .entries        (entries),
        .a_fwd          (a_fwd),
        .b_fwd          (b_fwd),
        .pipeline_ready (pipeline_ready),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .prf_req        (prf_req),
        .issue_mask     (issue_mask)
    );

endmodule

`default_nettype wire

// ==== bench/tb_stamofu_iq.sv ====
// --------------------------------------------------------------------------
// testbench for the store/amo/fence issue queue
// directed tests checked every cycle against an ordered queue model,
// with forward, latched wakeup, zero operand and back-pressure cases
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_stamofu_iq;

    import stamofu_pkg::*;

    // the tests run well under a hundred cycles
    localparam int MAX_CYCLES = 2000;

    logic     CLK;
    logic     nRST;
    logic     enq_valid;
    iq_enq_t  enq;
    logic     enq_ready;
    wb_bus_t  wb;
    logic     pipeline_ready;
    logic     issue_valid;
    issue_t   issue;
    prf_req_t prf_req;

    // ordered model with the oldest op first
    iq_enq_t     model_q[$];
    logic [31:0] rng;
    int          cycle_cnt;

    stamofu_iq dut0 (
        .CLK            (CLK),
        .nRST           (nRST),
        .enq_valid      (enq_valid),
        .enq            (enq),
        .enq_ready      (enq_ready),
        .wb             (wb),
        .pipeline_ready (pipeline_ready),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .prf_req        (prf_req)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // ----------------------------------------------------------------------
    // stimulus helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // random fields with both operands ready and nonzero
    task automatic new_op(output iq_enq_t op);
        rng     = xorshift32(rng);
        op.info = rng;
        rng     = xorshift32(rng);
        op.a.pr      = rng[5:0];
        op.a.ready   = 1'b1;
        op.a.is_zero = 1'b0;
        op.b.pr      = rng[13:8];
        op.b.ready   = 1'b1;
        op.b.is_zero = 1'b0;
    endtask

    function automatic wb_bus_t writeback_for(input pr_t pr);
        wb_bus_t w;
        w                = '0;
        w.valid[pr.bank] = 1'b1;
        w.upper[pr.bank] = pr.upper;
        return w;
    endfunction

    function automatic logic tag_hit(input pr_t pr, input wb_bus_t w);
        return w.valid[pr.bank] && (w.upper[pr.bank] == pr.upper);
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks

    task automatic verify_issue(input issue_t exp, input issue_t act);
        if (exp !== act) begin
            $display("[ERROR] issue expected %h got %h", exp, act);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic compare_prf_req(input prf_req_t exp, input prf_req_t act);
        if (exp !== act) begin
            $display("[ERROR] prf_req expected %h got %h", exp, act);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // ----------------------------------------------------------------------
    // queue model checked mid-cycle and then advanced past the next edge

    task automatic model_check();
        iq_enq_t  e;
        issue_t   exp_issue;
        prf_req_t exp_req;
        logic     a_f;
        logic     b_f;
        logic     room;
        int       pick;
        pick = -1;
        room = (model_q.size() < IQ_ENTRIES);
        for (int i = 0; i < model_q.size(); i++) begin
            e   = model_q[i];
            a_f = tag_hit(e.a.pr, wb);
            b_f = tag_hit(e.b.pr, wb);
            if (pick < 0 && pipeline_ready && (e.a.ready || a_f || e.a.is_zero) &&
                (e.b.ready || b_f || e.b.is_zero)) begin
                pick = i;
            end
        end
        expect_bit("enq_ready", room, enq_ready);
        expect_bit("issue_valid", pick >= 0, issue_valid);
        if (pick >= 0) begin
            e   = model_q[pick];
            a_f = tag_hit(e.a.pr, wb);
            b_f = tag_hit(e.b.pr, wb);
            exp_issue.info      = e.info;
            exp_issue.a_forward = a_f;
            exp_issue.a_is_zero = e.a.is_zero;
            exp_issue.a_bank    = e.a.pr.bank;
            exp_issue.b_forward = b_f;
            exp_issue.b_is_zero = e.b.is_zero;
            exp_issue.b_bank    = e.b.pr.bank;
            exp_req.a_valid = !a_f && !e.a.is_zero;
            exp_req.a_pr    = e.a.pr;
            exp_req.b_valid = !b_f && !e.b.is_zero;
            exp_req.b_pr    = e.b.pr;
            verify_issue(exp_issue, issue);
            compare_prf_req(exp_req, prf_req);
        end
        // forwards seen this cycle stick
        for (int i = 0; i < model_q.size(); i++) begin
            e         = model_q[i];
            e.a.ready = e.a.ready | tag_hit(e.a.pr, wb);
            e.b.ready = e.b.ready | tag_hit(e.b.pr, wb);
            model_q[i] = e;
        end
        if (pick >= 0) begin
            model_q.delete(pick);
        end
        if (enq_valid && room) begin
            model_q.push_back(enq);
        end
    endtask

    task automatic step(input logic ev, input iq_enq_t e, input wb_bus_t w, input logic pr);
        @(posedge CLK);
        enq_valid      <= ev;
        enq            <= e;
        wb             <= w;
        pipeline_ready <= pr;
        @(negedge CLK);
        model_check();
    endtask

    // ----------------------------------------------------------------------
    // directed tests

    task automatic reset_and_fill();
        iq_enq_t op;
        step(1'b0, '0, '0, 1'b0);
        expect_bit("enq_ready", 1'b1, enq_ready);
        expect_bit("issue_valid", 1'b0, issue_valid);
        for (int k = 0; k < IQ_ENTRIES; k++) begin
            new_op(op);
            step(1'b1, op, '0, 1'b0);
            expect_bit("issue_valid", 1'b0, issue_valid);
        end
        step(1'b0, '0, '0, 1'b0);
        expect_bit("enq_ready", 1'b0, enq_ready);
        expect_bit("issue_valid", 1'b0, issue_valid);
    endtask

    task automatic drain_in_order();
        int n;
        n = 0;
        while (model_q.size() != 0) begin
            step(1'b0, '0, '0, 1'b1);
            expect_bit("issue_valid", 1'b1, issue_valid);
            expect_bit("prf_req.a_valid", 1'b1, prf_req.a_valid);
            expect_bit("prf_req.b_valid", 1'b1, prf_req.b_valid);
            // slot freed by this issue only counts from the next cycle
            expect_bit("enq_ready", n != 0, enq_ready);
            n++;
        end
        if (n != IQ_ENTRIES) begin
            $display("drain issued %0d ops instead of %0d", n, IQ_ENTRIES);
            $display("Some tests failed");
            $fatal(1);
        end
        step(1'b0, '0, '0, 1'b1);
        expect_bit("issue_valid", 1'b0, issue_valid);
    endtask

    task automatic forward_at_issue();
        iq_enq_t op;
        iq_enq_t next_op;
        new_op(op);
        op.a.ready = 1'b0;
        new_op(next_op);
        step(1'b1, op, '0, 1'b1);
        repeat (3) begin
            step(1'b0, '0, '0, 1'b1);
            expect_bit("issue_valid", 1'b0, issue_valid);
        end
        // new op takes slot 0 as the forwarded op leaves it
        step(1'b1, next_op, writeback_for(op.a.pr), 1'b1);
        expect_bit("issue_valid", 1'b1, issue_valid);
        expect_bit("issue.a_forward", 1'b1, issue.a_forward);
        expect_bit("prf_req.a_valid", 1'b0, prf_req.a_valid);
        step(1'b0, '0, '0, 1'b1);
        expect_bit("issue_valid", 1'b1, issue_valid);
        step(1'b0, '0, '0, 1'b1);
        expect_bit("issue_valid", 1'b0, issue_valid);
    endtask

    task automatic latched_wakeup();
        iq_enq_t op;
        new_op(op);
        op.a.ready = 1'b0;
        step(1'b1, op, '0, 1'b0);
        step(1'b0, '0, '0, 1'b0);
        step(1'b0, '0, writeback_for(op.a.pr), 1'b0);
        expect_bit("issue_valid", 1'b0, issue_valid);
        step(1'b0, '0, '0, 1'b0);
        step(1'b0, '0, '0, 1'b1);
        expect_bit("issue_valid", 1'b1, issue_valid);
        expect_bit("issue.a_forward", 1'b0, issue.a_forward);
        expect_bit("prf_req.a_valid", 1'b1, prf_req.a_valid);
        step(1'b0, '0, '0, 1'b1);
    endtask

    task automatic zero_operand_bypass();
        iq_enq_t older;
        iq_enq_t younger;
        new_op(older);
        older.b.ready = 1'b0;
        new_op(younger);
        younger.b.ready   = 1'b0;
        younger.b.is_zero = 1'b1;
        step(1'b1, older, '0, 1'b1);
        step(1'b1, younger, '0, 1'b1);
        expect_bit("issue_valid", 1'b0, issue_valid);
        // younger entry passes the blocked older one
        step(1'b0, '0, '0, 1'b1);
        expect_bit("issue_valid", 1'b1, issue_valid);
        expect_bit("issue.b_is_zero", 1'b1, issue.b_is_zero);
        expect_bit("prf_req.b_valid", 1'b0, prf_req.b_valid);
        step(1'b0, '0, '0, 1'b1);
        expect_bit("issue_valid", 1'b0, issue_valid);
        step(1'b0, '0, writeback_for(older.b.pr), 1'b1);
        expect_bit("issue_valid", 1'b1, issue_valid);
        expect_bit("issue.b_forward", 1'b1, issue.b_forward);
        step(1'b0, '0, '0, 1'b1);
        expect_bit("issue_valid", 1'b0, issue_valid);
        expect_bit("enq_ready", 1'b1, enq_ready);
    endtask

    // ----------------------------------------------------------------------
    // main sequence

    initial begin
        nRST           = 1'b0;
        enq_valid      = 1'b0;
        enq            = '0;
        wb             = '0;
        pipeline_ready = 1'b0;
        cycle_cnt      = 0;
        rng            = 32'hdc3b;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;

        reset_and_fill();
        drain_in_order();
        forward_at_issue();
        latched_wakeup();
        zero_operand_bypass();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/stamofu_pkg.sv
src/iq_entry_array.sv
src/operand_wakeup.sv
src/issue_select.sv
src/stamofu_iq.sv
bench/tb_stamofu_iq.sv

// ==== run.sh ====
#!/bin/sh
# build and run the issue queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_stamofu_iq -Mdir obj_dir -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
